// File: trace_pkg.sv
package trace_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int TAG_W   = 6;                 // 64 tags, at most 5 in flight
    localparam int TAGS    = 2 ** TAG_W;        // Entries in the front store
    localparam int SLOTS   = 4;                 // Fetch or decode events kept per instruction
    localparam int SLOT_W  = $clog2(SLOTS);     // Slot index
    localparam int CNT_W   = $clog2(SLOTS + 1); // Count runs 0..SLOTS
    localparam int CODE_W  = 16;                // Stage event code
    localparam int CYCLE_W = 32;                // Cycle and retire counters

    // Plain vectors with a meaning
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [CODE_W-1:0]  evt_code_t;
    typedef logic [CNT_W-1:0]   cnt_t;
    typedef logic [SLOT_W-1:0]  slot_t;
    typedef logic [CYCLE_W-1:0] cycle_t;

    ////////////////////
    // Bundles
    ////////////////////

    // One stage's event input, single-cycle strobe
    typedef struct packed {
        logic      valid;
        evt_code_t code;
    } evt_strobe_t;

    // Tag and valid per stage, plus the fetch entry marker
    typedef struct packed {
        logic new_tag;      // High in the first cycle a tag sits in fetch
        tag_t fetch_tag;
        logic fetch_valid;
        tag_t decode_tag;
        logic decode_valid;
        tag_t exec_tag;
        logic exec_valid;
        tag_t mem_tag;
        logic mem_valid;
        tag_t wb_tag;
        logic wb_valid;
    } stage_ctl_t;

    // Front events for one tag, slots past the count read as zero
    typedef struct packed {
        cnt_t                  fetch_cnt;
        evt_code_t [SLOTS-1:0] fetch_code;
        cnt_t                  decode_cnt;
        evt_code_t [SLOTS-1:0] decode_code;
    } front_rec_t;

    // Back events, aligned with wb
    typedef struct packed {
        logic      exec_present;
        evt_code_t exec_code;
        logic      mem_present;
        evt_code_t mem_code;
    } back_rec_t;

    // Emitted once per instruction leaving wb
    typedef struct packed {
        tag_t       tag;
        front_rec_t front;
        back_rec_t  back;
        logic       wb_present;
        evt_code_t  wb_code;
        cycle_t     cycle;      // Cycle counter value in the wb cycle
    } retire_rec_t;

endpackage

// File: stage_tracker.sv
`timescale 1ns/1ps

module stage_tracker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,    // Level, takes effect one edge later
    output trace_pkg::stage_ctl_t ctl
);
    import trace_pkg::*;

    logic       stall_q;    // Registered stall
    tag_t       next_tag_q; // Tag fetch takes at the next advance
    stage_ctl_t ctl_q;      // Stage tags and valids

    ////////////////////
    // Stall register
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall;
        end
    end

    ////////////////////
    // Stage advance
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl_q      <= '0;   // All stages empty, tags at 0
            next_tag_q <= '0;   // First fetch gets tag 0
        end else begin
            // Back half moves every edge, stall or not
            ctl_q.mem_tag   <= ctl_q.exec_tag;
            ctl_q.mem_valid <= ctl_q.exec_valid;
            ctl_q.wb_tag    <= ctl_q.mem_tag;
            ctl_q.wb_valid  <= ctl_q.mem_valid;

            if (stall_q) begin
                // Fetch and decode hold their instruction
                ctl_q.exec_valid <= 1'b0;   // Bubble into exec
                ctl_q.new_tag    <= 1'b0;   // Same tag stays in fetch
            end else begin
                ctl_q.fetch_tag    <= next_tag_q;
                ctl_q.fetch_valid  <= 1'b1;
                ctl_q.decode_tag   <= ctl_q.fetch_tag;
                ctl_q.decode_valid <= ctl_q.fetch_valid;
                ctl_q.exec_tag     <= ctl_q.decode_tag;
                ctl_q.exec_valid   <= ctl_q.decode_valid;
                ctl_q.new_tag      <= 1'b1;                 // Front store clears this tag
                next_tag_q         <= next_tag_q + 1'b1;    // Wraps past 63
            end
        end
    end

    assign ctl = ctl_q;

endmodule

// File: front_recorder.sv
`timescale 1ns/1ps

module front_recorder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  trace_pkg::stage_ctl_t  ctl,
    input  trace_pkg::evt_strobe_t fetch_evt,
    input  trace_pkg::evt_strobe_t decode_evt,
    input  trace_pkg::tag_t        rd_tag,  // Tag in wb
    output trace_pkg::front_rec_t  rd_rec
);
    import trace_pkg::*;

    ////////////////////
    // Per-tag store
    ////////////////////
    cnt_t      fetch_cnt_q   [TAGS];
    cnt_t      decode_cnt_q  [TAGS];
    evt_code_t fetch_code_q  [TAGS][SLOTS];
    evt_code_t decode_code_q [TAGS][SLOTS];

    cnt_t  fetch_cnt_cur;   // Fetch count as seen this cycle
    cnt_t  decode_cnt_cur;  // Decode count as seen this cycle
    logic  fetch_acc;       // Fetch event accepted at this edge
    logic  decode_acc;      // Decode event accepted at this edge
    slot_t fetch_slot;
    slot_t decode_slot;
    cnt_t  rd_fetch_cnt;
    cnt_t  rd_decode_cnt;

    // On the entry cycle the stored count is stale, treat it as empty
    assign fetch_cnt_cur  = ctl.new_tag ? '0 : fetch_cnt_q[ctl.fetch_tag];
    assign decode_cnt_cur = decode_cnt_q[ctl.decode_tag];

    // Saturate at SLOTS, later events dropped
    assign fetch_acc  = ctl.fetch_valid && fetch_evt.valid && (fetch_cnt_cur < cnt_t'(SLOTS));
    assign decode_acc = ctl.decode_valid && decode_evt.valid
                        && (decode_cnt_cur < cnt_t'(SLOTS));

    assign fetch_slot  = fetch_cnt_cur[SLOT_W-1:0];    // Append position
    assign decode_slot = decode_cnt_cur[SLOT_W-1:0];

    ////////////////////
    // Counts
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int t = 0; t < TAGS; t++) begin
                fetch_cnt_q[t]  <= '0;
                decode_cnt_q[t] <= '0;
            end
        end else begin
            if (ctl.new_tag) begin
                fetch_cnt_q[ctl.fetch_tag]  <= '0;   // Fresh instruction
                decode_cnt_q[ctl.fetch_tag] <= '0;
            end
            if (fetch_acc) begin
                fetch_cnt_q[ctl.fetch_tag] <= fetch_cnt_cur + 1'b1;
            end
            if (decode_acc) begin
                decode_cnt_q[ctl.decode_tag] <= decode_cnt_cur + 1'b1;
            end
        end
    end

    // Event codes
    always_ff @(posedge clk) begin
        if (fetch_acc) begin
            fetch_code_q[ctl.fetch_tag][fetch_slot] <= fetch_evt.code;
        end
        if (decode_acc) begin
            decode_code_q[ctl.decode_tag][decode_slot] <= decode_evt.code;
        end
    end

    ////////////////////
    // Read port
    ////////////////////
    assign rd_fetch_cnt  = fetch_cnt_q[rd_tag];
    assign rd_decode_cnt = decode_cnt_q[rd_tag];

    always_comb begin
        rd_rec.fetch_cnt  = rd_fetch_cnt;
        rd_rec.decode_cnt = rd_decode_cnt;
        for (int s = 0; s < SLOTS; s++) begin
            // Slots past the count hold old codes, show them as zero
            rd_rec.fetch_code[s]  = (s < rd_fetch_cnt) ? fetch_code_q[rd_tag][s] : '0;
            rd_rec.decode_code[s] = (s < rd_decode_cnt) ? decode_code_q[rd_tag][s] : '0;
        end
    end

endmodule

// File: back_recorder.sv
`timescale 1ns/1ps

module back_recorder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  trace_pkg::stage_ctl_t  ctl,
    input  trace_pkg::evt_strobe_t exec_evt,
    input  trace_pkg::evt_strobe_t mem_evt,
    output trace_pkg::back_rec_t   wb_back   // Belongs to the instruction in wb
);
    import trace_pkg::*;

    logic      exec_acc;        // Exec event taken this edge
    logic      mem_acc;         // Mem event taken this edge
    logic      exec_hit_q;      // Exec code present, mem stage copy
    evt_code_t exec_code_q;
    back_rec_t wb_q;            // Both codes, wb stage copy

    // Exec and mem hold an instruction for one cycle only
    assign exec_acc = ctl.exec_valid & exec_evt.valid;
    assign mem_acc  = ctl.mem_valid & mem_evt.valid;

    ////////////////////
    // Present bits
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exec_hit_q          <= 1'b0;
            wb_q.exec_present   <= 1'b0;
            wb_q.mem_present    <= 1'b0;
        end else begin
            exec_hit_q        <= exec_acc;      // Bubble leaves it low
            wb_q.exec_present <= exec_hit_q;
            wb_q.mem_present  <= mem_acc;
        end
    end

    // Codes follow the same advance, zero when absent
    always_ff @(posedge clk) begin
        exec_code_q    <= exec_acc ? exec_evt.code : '0;
        wb_q.exec_code <= exec_code_q;
        wb_q.mem_code  <= mem_acc ? mem_evt.code : '0;
    end

    assign wb_back = wb_q;

endmodule

// File: retire_reporter.sv
`timescale 1ns/1ps

module retire_reporter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  trace_pkg::stage_ctl_t  ctl,
    input  trace_pkg::evt_strobe_t wb_evt,
    input  trace_pkg::front_rec_t  front_rec,     // Read at rd_tag
    input  trace_pkg::back_rec_t   back_rec,
    output trace_pkg::tag_t        rd_tag,        // Front store read address
    output logic                   retire_valid,
    output trace_pkg::retire_rec_t retire_rec,
    output trace_pkg::cycle_t      retired_count
);
    import trace_pkg::*;

    cycle_t cycle_q;    // Free-running, 0 in the first cycle after reset
    logic   wb_acc;     // Wb event taken with the record

    assign rd_tag = ctl.wb_tag;     // Front record for the retiring tag
    assign wb_acc = ctl.wb_valid & wb_evt.valid;

    ////////////////////
    // Counters
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_q       <= '0;
            retire_valid  <= 1'b0;
            retired_count <= '0;
        end else begin
            cycle_q      <= cycle_q + 1'b1;
            retire_valid <= ctl.wb_valid;   // Pulse one cycle after wb
            if (ctl.wb_valid) begin
                retired_count <= retired_count + 1'b1;
            end
        end
    end

    ////////////////////
    // Retire record
    ////////////////////
    always_ff @(posedge clk) begin
        if (ctl.wb_valid) begin
            retire_rec.tag        <= ctl.wb_tag;
            retire_rec.front      <= front_rec;
            retire_rec.back       <= back_rec;
            retire_rec.wb_present <= wb_acc;
            retire_rec.wb_code    <= wb_acc ? wb_evt.code : '0;
            retire_rec.cycle      <= cycle_q;   // Wb cycle, not the output cycle
        end
    end

endmodule

// File: pipe_trace_top.sv
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  trace_pkg::evt_strobe_t fetch_evt,
    input  trace_pkg::evt_strobe_t decode_evt,
    input  trace_pkg::evt_strobe_t exec_evt,
    input  trace_pkg::evt_strobe_t mem_evt,
    input  trace_pkg::evt_strobe_t wb_evt,
    output logic                   retire_valid,
    output trace_pkg::retire_rec_t retire_rec,
    output trace_pkg::cycle_t      retired_count
);
    import trace_pkg::*;

    stage_ctl_t ctl;        // Stage tags and valids, to every block
    front_rec_t front_rec;  // Front record at the wb tag
    back_rec_t  wb_back;    // Exec and mem codes for wb
    tag_t       rd_tag;     // Wb tag into the front store

    ////////////////////
    // Stage tracking
    ////////////////////
    stage_tracker u_stage_tracker (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .ctl   (ctl)
    );

    ////////////////////
    // Event recorders
    ////////////////////
    front_recorder u_front_recorder (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctl        (ctl),
        .fetch_evt  (fetch_evt),
        .decode_evt (decode_evt),
        .rd_tag     (rd_tag),
        .rd_rec     (front_rec)
    );

    back_recorder u_back_recorder (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (ctl),
        .exec_evt (exec_evt),
        .mem_evt  (mem_evt),
        .wb_back  (wb_back)
    );

    // Record out at retirement
    retire_reporter u_retire_reporter (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctl           (ctl),
        .wb_evt        (wb_evt),
        .front_rec     (front_rec),
        .back_rec      (wb_back),
        .rd_tag        (rd_tag),
        .retire_valid  (retire_valid),
        .retire_rec    (retire_rec),
        .retired_count (retired_count)
    );

endmodule

// File: tb_pipe_trace.sv
`timescale 1ns/1ps

module tb_pipe_trace;
    import trace_pkg::*;

    ////////////////////
    // Run length
    ////////////////////
    localparam int RESET_CYC = 3;
    localparam int IDLE_CYC  = 6;      // Neither strobes nor stall
    localparam int FLOW_CYC  = 16;     // Every strobe on without stall
    localparam int STALL_CYC = 16;     // Stall held and then released
    localparam int GAP_CYC   = 12;     // Back strobes left out
    localparam int RAND_CYC  = 400;
    localparam int DRAIN_CYC = 10;
    localparam int TOTAL_CYC = RESET_CYC + IDLE_CYC + FLOW_CYC + STALL_CYC
                               + GAP_CYC + RAND_CYC + DRAIN_CYC;
    localparam int TIMEOUT_CYC = 2 * TOTAL_CYC + 20;

    // DUT side
    logic        clk;
    logic        rst_n;
    logic        stall;
    evt_strobe_t fetch_evt;
    evt_strobe_t decode_evt;
    evt_strobe_t exec_evt;
    evt_strobe_t mem_evt;
    evt_strobe_t wb_evt;
    logic        retire_valid;
    retire_rec_t retire_rec;
    cycle_t      retired_count;

    // Reference model state stepped once per edge
    logic      m_stall_q;
    tag_t      m_next_tag;
    tag_t      m_f_tag, m_d_tag, m_e_tag, m_m_tag, m_w_tag;
    logic      m_f_vld, m_d_vld, m_e_vld, m_m_vld, m_w_vld;
    cnt_t      m_fcnt  [TAGS];
    cnt_t      m_dcnt  [TAGS];
    evt_code_t m_fcode [TAGS][SLOTS];
    evt_code_t m_dcode [TAGS][SLOTS];
    logic      m_m_exec_hit;            // Exec event of the instruction in mem
    evt_code_t m_m_exec_code;
    back_rec_t m_w_back;                // Back events of the instruction in wb
    cycle_t    m_cycle;
    cycle_t    m_retired;

    retire_rec_t exp_q [$];             // Records due on the next cycle
    logic        first_done = 1'b0;
    int          tb_cycles  = 0;

    pipe_trace_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .fetch_evt     (fetch_evt),
        .decode_evt    (decode_evt),
        .exec_evt      (exec_evt),
        .mem_evt       (mem_evt),
        .wb_evt        (wb_evt),
        .retire_valid  (retire_valid),
        .retire_rec    (retire_rec),
        .retired_count (retired_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Stage number in the top nibble keeps codes apart
    function automatic evt_strobe_t make_evt(input logic vld, input logic [3:0] stage,
                                             input logic [11:0] seq);
        evt_strobe_t e;
        e.valid = vld;
        e.code  = {stage, seq};
        return e;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic compare_record(input retire_rec_t want);
        check_value("tag", retire_rec.tag, want.tag);
        check_value("fetch_cnt", retire_rec.front.fetch_cnt, want.front.fetch_cnt);
        check_value("decode_cnt", retire_rec.front.decode_cnt, want.front.decode_cnt);
        for (int s = 0; s < SLOTS; s++) begin
            check_value($sformatf("fetch_code[%0d]", s), retire_rec.front.fetch_code[s],
                        want.front.fetch_code[s]);
            check_value($sformatf("decode_code[%0d]", s), retire_rec.front.decode_code[s],
                        want.front.decode_code[s]);
        end
        check_value("exec_present", retire_rec.back.exec_present, want.back.exec_present);
        check_value("exec_code", retire_rec.back.exec_code, want.back.exec_code);
        check_value("mem_present", retire_rec.back.mem_present, want.back.mem_present);
        check_value("mem_code", retire_rec.back.mem_code, want.back.mem_code);
        check_value("wb_present", retire_rec.wb_present, want.wb_present);
        check_value("wb_code", retire_rec.wb_code, want.wb_code);
        check_value("retire cycle", retire_rec.cycle, want.cycle);
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    // Reads the inputs of the cycle that ends at this edge
    function automatic void model_step();
        retire_rec_t rec;
        if (!rst_n) begin
            m_stall_q  = 1'b0;
            m_next_tag = '0;
            {m_f_vld, m_d_vld, m_e_vld, m_m_vld, m_w_vld} = '0;
            {m_f_tag, m_d_tag, m_e_tag, m_m_tag, m_w_tag} = '0;
            for (int t = 0; t < TAGS; t++) begin
                m_fcnt[t] = '0;
                m_dcnt[t] = '0;
                for (int s = 0; s < SLOTS; s++) begin
                    m_fcode[t][s] = '0;
                    m_dcode[t][s] = '0;
                end
            end
            m_m_exec_hit  = 1'b0;
            m_m_exec_code = '0;
            m_w_back      = '0;
            m_cycle       = '0;
            m_retired     = '0;
            exp_q.delete();
        end else begin
            // Instruction leaving wb
            if (m_w_vld) begin
                rec.tag              = m_w_tag;
                rec.front.fetch_cnt  = m_fcnt[m_w_tag];
                rec.front.decode_cnt = m_dcnt[m_w_tag];
                for (int s = 0; s < SLOTS; s++) begin
                    rec.front.fetch_code[s]  = m_fcode[m_w_tag][s];
                    rec.front.decode_code[s] = m_dcode[m_w_tag][s];
                end
                rec.back       = m_w_back;
                rec.wb_present = wb_evt.valid;
                rec.wb_code    = wb_evt.valid ? wb_evt.code : '0;
                rec.cycle      = m_cycle;       // Counter in the wb cycle
                exp_q.push_back(rec);
                m_retired++;
            end
            // Front events append until the slots are full
            if (m_f_vld && fetch_evt.valid && m_fcnt[m_f_tag] < SLOTS) begin
                m_fcode[m_f_tag][m_fcnt[m_f_tag]] = fetch_evt.code;
                m_fcnt[m_f_tag]++;
            end
            if (m_d_vld && decode_evt.valid && m_dcnt[m_d_tag] < SLOTS) begin
                m_dcode[m_d_tag][m_dcnt[m_d_tag]] = decode_evt.code;
                m_dcnt[m_d_tag]++;
            end
            // Back events ride along with mem and wb
            m_w_back.exec_present = m_m_exec_hit;
            m_w_back.exec_code    = m_m_exec_code;
            m_w_back.mem_present  = m_m_vld && mem_evt.valid;
            m_w_back.mem_code     = (m_m_vld && mem_evt.valid) ? mem_evt.code : '0;
            m_m_exec_hit          = m_e_vld && exec_evt.valid;
            m_m_exec_code         = (m_e_vld && exec_evt.valid) ? exec_evt.code : '0;
            // Stage advance with the back half always moving
            m_w_tag = m_m_tag;
            m_w_vld = m_m_vld;
            m_m_tag = m_e_tag;
            m_m_vld = m_e_vld;
            if (m_stall_q) begin
                m_e_vld = 1'b0;     // Bubble
            end else begin
                m_e_tag = m_d_tag;
                m_e_vld = m_d_vld;
                m_d_tag = m_f_tag;
                m_d_vld = m_f_vld;
                m_f_tag = m_next_tag;
                m_f_vld = 1'b1;
                // New instruction starts with an empty front record
                m_fcnt[m_next_tag] = '0;
                m_dcnt[m_next_tag] = '0;
                for (int s = 0; s < SLOTS; s++) begin
                    m_fcode[m_next_tag][s] = '0;
                    m_dcode[m_next_tag][s] = '0;
                end
                m_next_tag++;
            end
            m_stall_q = stall;
            m_cycle++;
        end
    endfunction

    ////////////////////
    // Compare
    ////////////////////
    always @(posedge clk) begin : compare_proc
        retire_rec_t want;
        if (rst_n) begin
            check_value("retire_valid", retire_valid, exp_q.size() != 0);
            check_value("retired_count", retired_count, m_retired);
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                compare_record(want);
                if (!first_done) begin
                    // Tag 0 enters fetch in cycle 1 and reaches wb in cycle 5
                    check_value("first retired tag", retire_rec.tag, 0);
                    check_value("first retire cycle", retire_rec.cycle, 5);
                    first_done = 1'b1;
                end
            end
        end
        model_step();
    end

    // Hang guard
    always @(posedge clk) begin
        tb_cycles <= tb_cycles + 1;
        if (tb_cycles >= TIMEOUT_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("*** FAILED ***");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    // One cycle of stimulus with strobes ordered {wb, mem, exec, decode, fetch}
    task automatic drive_cycle(input logic stall_in, input logic [4:0] strobes,
                               input logic [11:0] seq);
        @(posedge clk);
        stall      <= stall_in;
        fetch_evt  <= make_evt(strobes[0], 4'h1, seq);
        decode_evt <= make_evt(strobes[1], 4'h2, seq);
        exec_evt   <= make_evt(strobes[2], 4'h3, seq);
        mem_evt    <= make_evt(strobes[3], 4'h4, seq);
        wb_evt     <= make_evt(strobes[4], 4'h5, seq);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin : stimulus
        logic [31:0] rng;
        rng        = 32'd79;
        rst_n      = 1'b0;
        stall      = 1'b0;
        fetch_evt  = '0;
        decode_evt = '0;
        exec_evt   = '0;
        mem_evt    = '0;
        wb_evt     = '0;
        repeat (RESET_CYC) @(posedge clk);
        rst_n <= 1'b1;

        // Empty records retire one per cycle
        for (int i = 0; i < IDLE_CYC; i++) begin
            drive_cycle(1'b0, 5'b00000, 12'(i));
        end
        // Full flow
        for (int i = 0; i < FLOW_CYC; i++) begin
            drive_cycle(1'b0, 5'b11111, 12'(12'h100 + i));
        end
        // Long stall saturates the front counts
        for (int i = 0; i < STALL_CYC; i++) begin
            drive_cycle(i < 7, 5'b11111, 12'(12'h200 + i));
        end
        // Back events missing around a short stall
        for (int i = 0; i < GAP_CYC; i++) begin
            drive_cycle((i == 5) || (i == 6),
                        {(i % 4) != 1, (i % 3) == 0, i[0], 1'b1, !i[1]},
                        12'(12'h300 + i));
        end
        // Random run that wraps the tags several times
        for (int i = 0; i < RAND_CYC; i++) begin
            rng = xorshift32(rng);
            drive_cycle(rng[1:0] == 2'b00, rng[6:2] | rng[11:7], rng[23:12]);
        end
        for (int i = 0; i < DRAIN_CYC; i++) begin
            drive_cycle(1'b0, 5'b00000, 12'hfff);
        end

        @(negedge clk);     // Outputs and model settled
        check_value("final retired_count", retired_count, m_retired);
        check_value("final retire_valid", retire_valid, exp_q.size() != 0);
        if (exp_q.size() != 0) begin
            compare_record(exp_q.pop_front());  // Last record still on the outputs
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: pipe_trace_top.f
trace_pkg.sv
stage_tracker.sv
front_recorder.sv
back_recorder.sv
retire_reporter.sv
pipe_trace_top.sv
tb_pipe_trace.sv

// File: Bender.yml
package:
  name: pipe_trace

sources:
  - trace_pkg.sv
  - stage_tracker.sv
  - front_recorder.sv
  - back_recorder.sv
  - retire_reporter.sv
  - pipe_trace_top.sv
  - target: simulation
    files:
      - tb_pipe_trace.sv
